// ==== project.f ====
+incdir+common
common/decodePkg.sv
src/fetchGroupSplit.sv
decodeLane/decodeRs2.sv
decodeLane/regMap.sv
decodeLane/decodeLane.sv
src/decodeCollect.sv
src/decodeGroup.sv
dv/decodeGroupTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 -Wno-fatal --timescale 1ns/1ps \
	--top-module decodeGroupTb -f project.f

out=$(./obj_dir/VdecodeGroupTb 2>&1) || true
echo "$out"

if echo "$out" | grep -qF "*** TEST PASSED ***"; then
	exit 0
else
	exit 1
fi

// ==== dv/decodeGroupTb.sv ====
/*
 * Testbench for the Rs2 decode stage
 * Clock, reset, LCG stimulus, reference model with a two-deep delay line,
 * concurrent checks, directed and random tests, watchdog and report
 */
`include "decode_settings.svh"

module decodeGroupTb;

	timeunit 1ns;
	timeprecision 1ps;

	import decodePkg::*;

	localparam int RstCycles = 16;
	localparam int RandomCycles = 2000;
	// Directed tests use well under this many cycles
	localparam int DirectedCycles = 400;
	localparam int WatchdogCycles = RstCycles + DirectedCycles + RandomCycles + 100;
	localparam int DrainLimit = 10;
	localparam int ValW = (`LANES * `PREG_W > 64) ? `LANES * `PREG_W : 64;

	logic                      clk;
	logic                      rstN;
	logic                      groupValid;
	logic [`LANES*`INSN_W-1:0] group;
	opModeE                    mode;
	logic                      outValid;
	logic [`LANES*`PREG_W-1:0] preg;
	logic [`LANES-1:0]         hasRs2Mask;
	logic [`LANES-1:0]         rs2ZeroMask;
	logic [`LANES-1:0]         excMask;
	logic                      excAny;
	logic [`LANE_W-1:0]        excLane;

	// Expected results, stage 1 and stage 2 of the delay line
	logic                      expValid1;
	logic                      expValid2;
	logic [`LANES-1:0]         expHas1;
	logic [`LANES-1:0]         expHas2;
	logic [`LANES-1:0]         expZero1;
	logic [`LANES-1:0]         expZero2;
	logic [`LANES-1:0]         expExc1;
	logic [`LANES-1:0]         expExc2;
	logic [`LANES*`PREG_W-1:0] expPreg1;
	logic [`LANES*`PREG_W-1:0] expPreg2;
	int                        expLane1;
	int                        expLane2;

	logic [31:0] seed;
	opcodeE      opList [15];
	string       testName;
	int          errorCount;
	int          startErrors;
	int          testCount;
	int          sentCount;
	int          seenCount;

	decodeGroup uut
	(
		.clk        (clk),
		.rstN       (rstN),
		.groupValid (groupValid),
		.group      (group),
		.mode       (mode),
		.outValid   (outValid),
		.preg       (preg),
		.hasRs2Mask (hasRs2Mask),
		.rs2ZeroMask(rs2ZeroMask),
		.excMask    (excMask),
		.excAny     (excAny),
		.excLane    (excLane)
	);

	always #5 clk = ~clk;

	// ==========================================================
	// Stimulus helpers
	// ==========================================================

	function automatic logic [31:0] nextRandom();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// Fields the decoder ignores are filled with random bits
	function automatic logic [`INSN_W-1:0] makeInsn(input logic [6:0] op, input logic [2:0] top,
		input logic [4:0] aluReg, input logic [4:0] memReg, input logic [2:0] cond);
		logic [`INSN_W-1:0] insn;
		insn = nextRandom();
		insn[6:0] = op;
		insn[10:8] = cond;
		insn[17:13] = aluReg;
		insn[27:23] = memReg;
		insn[31:29] = top;
		return insn;
	endfunction

	// Mostly listed opcodes, now and then a raw code that has no Rs2
	function automatic logic [`LANES*`INSN_W-1:0] randomGroup();
		logic [`LANES*`INSN_W-1:0] g;
		logic [31:0]               r;
		logic [`INSN_W-1:0]        insn;
		for (int i = 0; i < `LANES; i++)
		begin
			r = nextRandom();
			insn = nextRandom();
			insn[6:0] = (r[7:4] == 4'd15) ? r[14:8] : opList[r[7:4]];
			if (r[16])
				insn[31:29] = 3'd0;
			g[i*`INSN_W +: `INSN_W] = insn;
		end
		return g;
	endfunction

	task automatic driveCycle(input logic valid, input logic [`LANES*`INSN_W-1:0] g,
		input opModeE m);
		@(posedge clk);
		groupValid <= valid;
		group <= g;
		mode <= m;
		if (valid)
			sentCount++;
	endtask

	task automatic beginTest(input string name);
		testName = name;
		startErrors = errorCount;
	endtask

	// Drops the strobe and waits until every group sent has come out
	task automatic finishTest();
		int waited;
		waited = 0;
		driveCycle(1'b0, '0, modeUser);
		while (seenCount != sentCount && waited < DrainLimit)
		begin
			@(posedge clk);
			waited++;
		end
		if (seenCount != sentCount)
		begin
			errorCount++;
			$display("Test %s: %0d groups went in but only %0d results came out",
				testName, sentCount, seenCount);
		end
		testCount++;
		$display("Test %-10s finished with %0d errors", testName, errorCount - startErrors);
	endtask

	// ==========================================================
	// Reference model
	// ==========================================================

	function automatic void expectLane(input logic [`INSN_W-1:0] insn, input opModeE m,
		output logic has, output logic zero, output pregT p, output logic exc);
		logic [6:0] op;
		logic       isAlu;
		logic       isMem;
		logic       immForm;
		int         regIdx;
		int         regCls;
		int         pv;
		op = insn[6:0];
		isAlu = op inside {opAdd, opSub, opAnd, opOr, opXor, opShift, opMul, opCmp};
		isMem = (op == opLoad) || (op == opStore);
		immForm = (isAlu || isMem) && (insn[31:29] != 3'd0);
		regIdx = (isMem || op == opAmo) ? int'(insn[27:23]) : int'(insn[17:13]);
		regCls = (op == opFlt) ? 1 : 0;
		if (isAlu || isMem)
			has = !immForm;
		else if (op == opFlt || op == opAmo)
			has = 1'b1;
		else if (op == opCsr)
			has = (insn[31:29] == 3'd0);
		else if (op == opBcc)
			has = (insn[10:8] != 3'd7);
		else
			has = 1'b0;
		if (!has)
		begin
			regIdx = 0;
			regCls = 0;
		end
		zero = (regIdx == 0) && (regCls == 0);
		if (regCls == 1)
			pv = 128 + regIdx;
		else if (regIdx >= 24)
			pv = 32 + int'(m) * 8 + regIdx - 24;
		else
			pv = regIdx;
		p = pregT'(pv);
		exc = has && (m == modeUser) && (regCls == 0) && (regIdx >= 28);
	endfunction

	// Sees the same inputs as the splitter on the same edge
	always @(posedge clk or negedge rstN)
	begin
		logic [`LANES-1:0]         h;
		logic [`LANES-1:0]         z;
		logic [`LANES-1:0]         e;
		logic [`LANES*`PREG_W-1:0] p;
		logic                      hb;
		logic                      zb;
		logic                      eb;
		pregT                      pb;
		int                        low;
		if (!rstN)
		begin
			expValid1 <= 1'b0;
			expValid2 <= 1'b0;
			expHas1 <= '0;
			expHas2 <= '0;
			expZero1 <= '0;
			expZero2 <= '0;
			expExc1 <= '0;
			expExc2 <= '0;
			expLane1 <= 0;
			expLane2 <= 0;
		end
		else
		begin
			h = '0;
			z = '0;
			e = '0;
			p = expPreg1;
			low = -1;
			if (groupValid)
			begin
				for (int i = 0; i < `LANES; i++)
				begin
					expectLane(group[i*`INSN_W +: `INSN_W], mode, hb, zb, pb, eb);
					h[i] = hb;
					z[i] = zb;
					e[i] = eb;
					p[i*`PREG_W +: `PREG_W] = pb;
					if (eb && low < 0)
						low = i;
				end
			end
			expValid1 <= groupValid;
			expHas1 <= h;
			expZero1 <= z;
			expExc1 <= e;
			expPreg1 <= p;
			expLane1 <= (low < 0) ? 0 : low;
			expValid2 <= expValid1;
			expHas2 <= expHas1;
			expZero2 <= expZero1;
			expExc2 <= expExc1;
			expPreg2 <= expPreg1;
			expLane2 <= expLane1;
		end
	end

	always @(posedge clk)
	begin
		if (outValid)
			seenCount <= seenCount + 1;
	end

	// ==========================================================
	// Checks
	// ==========================================================

	function automatic void reportMismatch(input string what, input logic [ValW-1:0] expVal,
		input logic [ValW-1:0] actVal);
		errorCount++;
		$display("CHECK FAILED test %s: %s expected %0h actual %0h",
			testName, what, expVal, actVal);
	endfunction

	validMatch: assert property (@(posedge clk) disable iff (!rstN) outValid == expValid2)
		else reportMismatch("outValid", $sampled(expValid2), $sampled(outValid));
	rs2MaskMatch: assert property (@(posedge clk) disable iff (!rstN) hasRs2Mask == expHas2)
		else reportMismatch("hasRs2Mask", $sampled(expHas2), $sampled(hasRs2Mask));
	zeroMaskMatch: assert property (@(posedge clk) disable iff (!rstN) rs2ZeroMask == expZero2)
		else reportMismatch("rs2ZeroMask", $sampled(expZero2), $sampled(rs2ZeroMask));
	excMaskMatch: assert property (@(posedge clk) disable iff (!rstN) excMask == expExc2)
		else reportMismatch("excMask", $sampled(expExc2), $sampled(excMask));
	excFlagMatch: assert property (@(posedge clk) disable iff (!rstN) excAny == |expExc2)
		else reportMismatch("excAny", $sampled(|expExc2), $sampled(excAny));
	laneMatch: assert property (@(posedge clk) disable iff (!rstN) int'(excLane) == expLane2)
		else reportMismatch("excLane", $sampled(expLane2), $sampled(excLane));
	// Physical numbers are only meaningful with a valid group
	pregMatch: assert property (@(posedge clk) disable iff (!rstN)
		expValid2 |-> preg == expPreg2)
		else reportMismatch("preg", $sampled(expPreg2), $sampled(preg));

	// ==========================================================
	// Tests
	// ==========================================================

	initial
	begin
		logic [`LANES*`INSN_W-1:0] g;
		logic [31:0]               r;
		int                        idx;
		clk = 1'b0;
		rstN = 1'b0;
		groupValid = 1'b0;
		group = '0;
		mode = modeUser;
		seed = 32'h87ad9768;
		errorCount = 0;
		testCount = 0;
		sentCount = 0;
		seenCount = 0;
		opList = '{opAdd, opSub, opAnd, opOr, opXor, opShift, opMul, opCmp,
			opFlt, opCsr, opBcc, opLoad, opStore, opAmo, opNop};
		repeat (RstCycles) @(posedge clk);
		rstN <= 1'b1;

		// Outputs stay quiet while idle, then one lone group and a back-to-back run
		beginTest("pipeline");
		repeat (8) driveCycle(1'b0, '0, modeUser);
		driveCycle(1'b1, randomGroup(), modeSuper);
		repeat (3) driveCycle(1'b0, '0, modeUser);
		for (int k = 0; k < 6; k++)
			driveCycle(1'b1, randomGroup(), opModeE'(k % 4));
		finishTest();

		// Every opcode in register and immediate form, with and without condition 7
		beginTest("opcodes");
		for (int k = 0; k < 15; k++)
		begin
			for (int i = 0; i < `LANES; i++)
			begin
				r = nextRandom();
				g[i*`INSN_W +: `INSN_W] = makeInsn(opList[k], (i % 2 == 1) ? 3'd5 : 3'd0,
					r[4:0], r[9:5], (i % 4 >= 2) ? 3'd7 : r[12:10]);
			end
			driveCycle(1'b1, g, opModeE'(k % 4));
		end
		finishTest();

		// Register 0 named outright, and lanes with no operand at all
		beginTest("zeroReg");
		for (int i = 0; i < `LANES; i++)
		begin
			case (i % 4)
				0: g[i*`INSN_W +: `INSN_W] = makeInsn(opAdd, 3'd0, 5'd0, 5'd9, 3'd1);
				1: g[i*`INSN_W +: `INSN_W] = makeInsn(7'h00, 3'd0, 5'd7, 5'd7, 3'd1);
				2: g[i*`INSN_W +: `INSN_W] = makeInsn(opBcc, 3'd0, 5'd12, 5'd3, 3'd7);
				default: g[i*`INSN_W +: `INSN_W] = makeInsn(opLoad, 3'd0, 5'd6, 5'd0, 3'd0);
			endcase
		end
		driveCycle(1'b1, g, modeMachine);
		finishTest();

		// All 32 integer and float registers under each mode
		beginTest("mapping");
		for (int m = 0; m < 4; m++)
		begin
			for (int cls = 0; cls < 2; cls++)
			begin
				for (int base = 0; base < 32; base += `LANES)
				begin
					for (int i = 0; i < `LANES; i++)
					begin
						idx = (base + i) % 32;
						g[i*`INSN_W +: `INSN_W] = makeInsn((cls == 1) ? opFlt : opAdd, 3'd0,
							idx[4:0], 5'd1, 3'd0);
					end
					driveCycle(1'b1, g, opModeE'(m));
				end
			end
		end
		finishTest();

		// Privileged registers trap only in user mode and only as a real operand
		beginTest("privilege");
		for (int m = 0; m < 4; m++)
		begin
			for (int i = 0; i < `LANES; i++)
			begin
				case (i % 4)
					0: g[i*`INSN_W +: `INSN_W] = makeInsn(opAdd, 3'd0, 5'd5, 5'd0, 3'd0);
					1: g[i*`INSN_W +: `INSN_W] = makeInsn(opLoad, 3'd0, 5'd0, 5'd29, 3'd0);
					2: g[i*`INSN_W +: `INSN_W] = makeInsn(opAmo, 3'd4, 5'd0, 5'd30, 3'd0);
					default: g[i*`INSN_W +: `INSN_W] = makeInsn(opBcc, 3'd0, 5'd28, 5'd0, 3'd2);
				endcase
			end
			driveCycle(1'b1, g, opModeE'(m));
			for (int i = 0; i < `LANES; i++)
			begin
				case (i % 4)
					0: g[i*`INSN_W +: `INSN_W] = makeInsn(opCsr, 3'd0, 5'd31, 5'd0, 3'd0);
					1: g[i*`INSN_W +: `INSN_W] = makeInsn(opAdd, 3'd3, 5'd28, 5'd0, 3'd0);
					2: g[i*`INSN_W +: `INSN_W] = makeInsn(opFlt, 3'd0, 5'd30, 5'd0, 3'd0);
					default: g[i*`INSN_W +: `INSN_W] = makeInsn(opBcc, 3'd0, 5'd29, 5'd0, 3'd7);
				endcase
			end
			driveCycle(1'b1, g, opModeE'(m));
			// Only the last lane of each four reads register 31 in register form
			for (int i = 0; i < `LANES; i++)
				g[i*`INSN_W +: `INSN_W] = makeInsn(opSub, (i % 4 == 3) ? 3'd0 : 3'd6,
					5'd31, 5'd0, 3'd0);
			driveCycle(1'b1, g, opModeE'(m));
		end
		finishTest();

		// Random strobes, modes and instructions
		beginTest("random");
		for (int k = 0; k < RandomCycles; k++)
		begin
			r = nextRandom();
			driveCycle(r[1:0] != 2'd0, randomGroup(), opModeE'(r[3:2]));
		end
		finishTest();

		$display("%0d tests run, %0d errors", testCount, errorCount);
		if (errorCount == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	// ==========================================================
	// Watchdog
	// ==========================================================

	initial
	begin
		repeat (WatchdogCycles) @(posedge clk);
		$display("Timeout: the tests did not finish within %0d cycles", WatchdogCycles);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== src/decodeGroup.sv ====
/*
 * Top of the Rs2 decode stage
 * Splitter, one decode lane per instruction, result collector
 */
`include "decode_settings.svh"

module decodeGroup
(
	input  logic                      clk,
	input  logic                      rstN,
	input  logic                      groupValid,
	input  logic [`LANES*`INSN_W-1:0] group,
	input  decodePkg::opModeE         mode,
	output logic                      outValid,
	output logic [`LANES*`PREG_W-1:0] preg,
	output logic [`LANES-1:0]         hasRs2Mask,
	output logic [`LANES-1:0]         rs2ZeroMask,
	output logic [`LANES-1:0]         excMask,
	output logic                      excAny,
	output logic [`LANE_W-1:0]        excLane
);

	import decodePkg::*;

	// Stage 1 outputs
	logic [`LANES*`INSN_W-1:0] instr;
	logic [`LANES-1:0]         laneValid;
	opModeE                    modeQ;
	// Combinational lane results
	logic [`LANES-1:0]         laneHasRs2;
	logic [`LANES-1:0]         laneRs2Zero;
	logic [`LANES-1:0]         laneExc;
	logic [`LANES*`PREG_W-1:0] lanePreg;

	fetchGroupSplit uSplit
	(
		.clk       (clk),
		.rstN      (rstN),
		.groupValid(groupValid),
		.group     (group),
		.mode      (mode),
		.instr     (instr),
		.laneValid (laneValid),
		.modeQ     (modeQ)
	);

	// Every lane reads the same registered mode
	for (genvar i = 0; i < `LANES; i++)
	begin : gLane
		decodeLane uLane
		(
			.instr  (instr[i*`INSN_W +: `INSN_W]),
			.mode   (modeQ),
			.hasRs2 (laneHasRs2[i]),
			.rs2Zero(laneRs2Zero[i]),
			.preg   (lanePreg[i*`PREG_W +: `PREG_W]),
			.exc    (laneExc[i])
		);
	end

	decodeCollect uCollect
	(
		.clk        (clk),
		.rstN       (rstN),
		.laneValid  (laneValid),
		.hasRs2     (laneHasRs2),
		.rs2Zero    (laneRs2Zero),
		.lanePreg   (lanePreg),
		.exc        (laneExc),
		.outValid   (outValid),
		.preg       (preg),
		.hasRs2Mask (hasRs2Mask),
		.rs2ZeroMask(rs2ZeroMask),
		.excMask    (excMask),
		.excAny     (excAny),
		.excLane    (excLane)
	);

endmodule

// ==== src/decodeCollect.sv ====
/*
 * Stage 2 register of the decode pipeline
 * Lane-valid gating, result masks and the lowest excepting lane
 */
`include "decode_settings.svh"

module decodeCollect
(
	input  logic                      clk,
	input  logic                      rstN,
	input  logic [`LANES-1:0]         laneValid,
	input  logic [`LANES-1:0]         hasRs2,
	input  logic [`LANES-1:0]         rs2Zero,
	input  logic [`LANES*`PREG_W-1:0] lanePreg,
	input  logic [`LANES-1:0]         exc,
	output logic                      outValid,
	output logic [`LANES*`PREG_W-1:0] preg,
	output logic [`LANES-1:0]         hasRs2Mask,
	output logic [`LANES-1:0]         rs2ZeroMask,
	output logic [`LANES-1:0]         excMask,
	output logic                      excAny,
	output logic [`LANE_W-1:0]        excLane
);

	logic [`LANES-1:0]  hasRs2D;
	logic [`LANES-1:0]  rs2ZeroD;
	logic [`LANES-1:0]  excD;
	logic [`LANE_W-1:0] excLaneD;

	// ==========================================================
	// Gating and priority scan
	// ==========================================================

	// An idle lane contributes nothing to any mask
	assign hasRs2D = hasRs2 & laneValid;
	assign rs2ZeroD = rs2Zero & laneValid;
	assign excD = exc & laneValid;

	// Scan from the top so the lowest excepting lane wins
	always_comb
	begin
		excLaneD = '0;
		for (int i = `LANES - 1; i >= 0; i--)
			if (excD[i])
				excLaneD = i[`LANE_W-1:0];
	end

	// ==========================================================
	// Output register
	// ==========================================================

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			outValid <= 1'b0;
			hasRs2Mask <= '0;
			rs2ZeroMask <= '0;
			excMask <= '0;
			excAny <= 1'b0;
			excLane <= '0;
		end
		else
		begin
			outValid <= |laneValid;
			hasRs2Mask <= hasRs2D;
			rs2ZeroMask <= rs2ZeroD;
			excMask <= excD;
			excAny <= |excD;
			excLane <= excLaneD;
		end
	end

	// Physical numbers only move with a valid group
	always_ff @(posedge clk)
	begin
		if (|laneValid)
			preg <= lanePreg;
	end

	// Summary flag and lane index must agree with the mask they were built beside
	excAnyMatch: assert property (@(posedge clk) disable iff (!rstN)
		excAny == |excMask)
		else $error("excAny disagrees with excMask");
	excLaneLowest: assert property (@(posedge clk) disable iff (!rstN)
		excAny |-> excMask[excLane] && ((excMask & ((`LANES'(1) << excLane) - 1'b1)) == '0))
		else $error("excLane is not the lowest excepting lane");

endmodule

// ==== decodeLane/decodeLane.sv ====
/*
 * One decode lane
 * Immediate-form detect, Rs2 decode, register map and zero flag
 */
`include "decode_settings.svh"

module decodeLane
(
	input  logic [`INSN_W-1:0] instr,
	input  decodePkg::opModeE  mode,
	output logic               hasRs2,
	output logic               rs2Zero,
	output decodePkg::pregT    preg,
	output logic               exc
);

	import decodePkg::*;

	opcodeE op;
	logic   immCapable;
	logic   hasImm;
	aregT   rs2;

	assign op = opcodeE'(instr[6:0]);

	// ALU and memory opcodes have an immediate variant
	always_comb
	begin
		case (op)
			opAdd, opSub, opAnd, opOr, opXor, opShift, opMul, opCmp, opLoad, opStore:
				immCapable = 1'b1;
			default:
				immCapable = 1'b0;
		endcase
	end

	// Nonzero top bits mark the immediate variant
	assign hasImm = immCapable && (instr[31:29] != 3'd0);

	decodeRs2 uRs2
	(
		.instr (instr),
		.hasImm(hasImm),
		.hasRs2(hasRs2),
		.rs2   (rs2)
	);

	// Only a real operand can raise the privilege exception
	regMap uMap
	(
		.mode(mode),
		.areg(rs2),
		.used(hasRs2),
		.preg(preg),
		.exc (exc)
	);

	// Set both for register 0 and for a missing operand
	assign rs2Zero = (rs2 == '0);

endmodule

// ==== decodeLane/regMap.sv ====
/*
 * Architectural to physical register map
 * Banks integer registers 24 to 31 by mode, offsets float registers,
 * and flags user-mode use of the privileged integer registers
 */
`include "decode_settings.svh"

module regMap
(
	input  decodePkg::opModeE mode,
	input  decodePkg::aregT   areg,
	input  logic              used,
	output decodePkg::pregT   preg,
	output logic              exc
);

	import decodePkg::*;

	logic [1:0] regClass;
	logic [4:0] idx;

	assign regClass = areg[`AREG_W-1 -: 2];
	assign idx = areg[4:0];

	always_comb
	begin
		if (regClass == ClassFlt)
			// Float file sits at 128 and up
			preg = pregT'({3'b100, idx});
		else if (idx[4:3] == 2'b11)
			// 24 to 31 land at 32 + mode*8 + (idx-24), and idx-24 is just the low bits
			preg = pregT'({3'b001, mode, idx[2:0]});
		else
			preg = pregT'({3'b000, idx});
	end

	// Registers 28 to 31 belong to the kernel and trap when read from user mode
	assign exc = used && (mode == modeUser) && (regClass == ClassInt) && (idx[4:2] == 3'b111);

endmodule

// ==== decodeLane/decodeRs2.sv ====
/*
 * Rs2 operand decode
 * Decides whether an instruction reads a second source register and
 * returns its class and index, or zero when there is none
 */
`include "decode_settings.svh"

module decodeRs2
(
	input  logic [`INSN_W-1:0] instr,
	input  logic               hasImm,
	output logic               hasRs2,
	output decodePkg::aregT    rs2
);

	import decodePkg::*;

	opcodeE     op;
	logic [4:0] aluField;
	logic [4:0] memField;
	logic [2:0] topBits;
	logic [2:0] branchCond;

	// ==========================================================
	// Instruction fields
	// ==========================================================

	assign op = opcodeE'(instr[6:0]);
	// ALU, float, CSR and branch forms keep Rs2 in the middle of the word
	assign aluField = instr[17:13];
	// Memory forms keep Rs2 higher up, next to the displacement
	assign memField = instr[27:23];
	assign topBits = instr[31:29];
	assign branchCond = instr[10:8];

	// ==========================================================
	// Per-opcode decode
	// ==========================================================

	always_comb
	begin
		hasRs2 = 1'b0;
		rs2 = '0;
		case (op)
			// Register-register ALU forms only
			opAdd, opSub, opAnd, opOr, opXor, opShift, opMul, opCmp:
			begin
				hasRs2 = !hasImm;
				rs2 = {ClassInt, aluField};
			end
			// Float always reads a float register
			opFlt:
			begin
				hasRs2 = 1'b1;
				rs2 = {ClassFlt, aluField};
			end
			// Nonzero top bits select the immediate CSR form
			opCsr:
			begin
				hasRs2 = (topBits == 3'd0);
				rs2 = {ClassInt, aluField};
			end
			// Condition 7 is the unconditional branch, which compares nothing
			opBcc:
			begin
				hasRs2 = (branchCond != 3'd7);
				rs2 = {ClassInt, aluField};
			end
			// Indexed load and store read Rs2 as the index register
			opLoad, opStore:
			begin
				hasRs2 = !hasImm;
				rs2 = {ClassInt, memField};
			end
			opAmo:
			begin
				hasRs2 = 1'b1;
				rs2 = {ClassInt, memField};
			end
			default:
			begin
				hasRs2 = 1'b0;
			end
		endcase
		// Without an operand the number reads as register 0
		if (!hasRs2)
			rs2 = '0;
	end

endmodule

// ==== src/fetchGroupSplit.sv ====
/*
 * Stage 1 register of the decode pipeline
 * Captures a fetch group with its mode and fans the strobe out to every lane
 */
`include "decode_settings.svh"

module fetchGroupSplit
(
	input  logic                      clk,
	input  logic                      rstN,
	input  logic                      groupValid,
	input  logic [`LANES*`INSN_W-1:0] group,
	input  decodePkg::opModeE         mode,
	output logic [`LANES*`INSN_W-1:0] instr,
	output logic [`LANES-1:0]         laneValid,
	output decodePkg::opModeE         modeQ
);

	logic validQ;

	// Strobe is the only control state in this stage
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			validQ <= 1'b0;
		else
			validQ <= groupValid;
	end

	// Group and mode are loaded only with a strobe
	// Lane i reads its instruction from bits i*INSN_W upward of the flat bus
	always_ff @(posedge clk)
	begin
		if (groupValid)
		begin
			instr <= group;
			modeQ <= mode;
		end
	end

	// A group is valid as a whole, so every lane shares the strobe
	assign laneValid = {`LANES{validQ}};

	// Lanes are only ever all on or all off
	laneAllOrNone: assert property (@(posedge clk) disable iff (!rstN)
		laneValid == '0 || laneValid == '1)
		else $error("lane valid mask is partly set");

endmodule

// ==== common/decodePkg.sv ====
/*
 * Shared decode types
 *   opcodeE        major opcode held in instruction bits 6..0
 *   opModeE        processor operating mode
 *   aregT, pregT   architectural and physical register numbers
 */
`include "decode_settings.svh"

package decodePkg;

	// ==========================================================
	// Opcodes
	// ==========================================================

	// Codes not listed here decode as having no Rs2
	typedef enum logic [6:0]
	{
		opAdd   = 7'h04,
		opSub   = 7'h05,
		opAnd   = 7'h06,
		opOr    = 7'h07,
		opXor   = 7'h08,
		opShift = 7'h09,
		opMul   = 7'h0a,
		opCmp   = 7'h0b,
		opFlt   = 7'h0c,
		opCsr   = 7'h0d,
		opBcc   = 7'h0e,
		opLoad  = 7'h10,
		opStore = 7'h11,
		opAmo   = 7'h12,
		opNop   = 7'h7f
	} opcodeE;

	// ==========================================================
	// Operating mode and register numbers
	// ==========================================================

	// The mode value also selects the bank of registers 24 to 31
	typedef enum logic [1:0]
	{
		modeUser    = 2'd0,
		modeSuper   = 2'd1,
		modeHyper   = 2'd2,
		modeMachine = 2'd3
	} opModeE;

	typedef logic [`AREG_W-1:0] aregT;
	typedef logic [`PREG_W-1:0] pregT;

	// Register class in the top two bits of an architectural number
	localparam logic [1:0] ClassInt = 2'b00;
	localparam logic [1:0] ClassFlt = 2'b01;

endpackage

// ==== common/decode_settings.svh ====
/*
 * Sizes for the Rs2 decode stage
 * Lane count, instruction width, register-number widths, lane-index width
 */
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// Instructions in one fetch group
`define LANES 4
`define INSN_W 32
// Architectural number is a 2-bit class above a 5-bit index
`define AREG_W 7
`define PREG_W 8
// Width of a lane index, kept at one bit for a single-lane build
`define LANE_W (((`LANES) > 1) ? $clog2(`LANES) : 1)

`endif
